/* compile.f */
+incdir+dv
hdl/zynq_csr_pkg.sv
hdl/zynq_dram_pkg.sv
hdl/axil_csr_shell.sv
hdl/dram_port_monitor.sv
hdl/zynq_pl_top.sv
dv/tb_zynq_pl_top.sv

/* dv/tb_axil_tasks.svh */
// galois lfsr stepped once per bit taken
function automatic logic [31:0] rand_bits(input int nbits);
   logic [31:0] v;
   v = '0;
   for (int i = 0; i < nbits; i++) begin
      lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
      v = {v[30:0], lfsr_state[0]};
   end
   return v;
endfunction

// outputs are sampled on the falling edge and inputs change on the rising edge
// address and data offered together until the accepting edge
task automatic write_issue(input csr_addr_t addr, input axil_data_t data,
                           input axil_strb_t strb);
   int n;
   n = 0;
   @(posedge aclk_i);
   s_awaddr_i  <= addr;
   s_awvalid_i <= 1'b1;
   s_wdata_i   <= data;
   s_wstrb_i   <= strb;
   s_wvalid_i  <= 1'b1;
   @(negedge aclk_i);
   while (!s_awready_o && n < WAIT_LIMIT) begin
      @(negedge aclk_i);
      n++;
   end
   if (!s_awready_o) begin
      timeout_abort("s_awready_o on a write");
   end
   @(posedge aclk_i);
   s_awvalid_i <= 1'b0;
   s_wvalid_i  <= 1'b0;
endtask

task automatic write_resp();
   int n;
   n = 0;
   @(posedge aclk_i);
   s_bready_i <= 1'b1;
   @(negedge aclk_i);
   while (!s_bvalid_o && n < WAIT_LIMIT) begin
      @(negedge aclk_i);
      n++;
   end
   if (!s_bvalid_o) begin
      timeout_abort("s_bvalid_o");
   end
   check_equal(32'(s_bresp_o), 32'(RESP_OKAY), "write response");
   @(posedge aclk_i);
   s_bready_i <= 1'b0;
endtask

task automatic axil_write(input csr_addr_t addr, input axil_data_t data,
                          input axil_strb_t strb);
   write_issue(addr, data, strb);
   write_resp();
endtask

task automatic axil_read(input csr_addr_t addr, output axil_data_t data);
   int n;
   n = 0;
   @(posedge aclk_i);
   s_araddr_i  <= addr;
   s_arvalid_i <= 1'b1;
   @(negedge aclk_i);
   while (!s_arready_o && n < WAIT_LIMIT) begin
      @(negedge aclk_i);
      n++;
   end
   if (!s_arready_o) begin
      timeout_abort("s_arready_o");
   end
   @(posedge aclk_i);
   s_arvalid_i <= 1'b0;
   s_rready_i  <= 1'b1;
   n = 0;
   @(negedge aclk_i);
   while (!s_rvalid_o && n < WAIT_LIMIT) begin
      @(negedge aclk_i);
      n++;
   end
   if (!s_rvalid_o) begin
      timeout_abort("s_rvalid_o");
   end
   data = s_rdata_o;
   check_equal(32'(s_rresp_o), 32'(RESP_OKAY), "read response");
   @(posedge aclk_i);
   s_rready_i <= 1'b0;
endtask

// read with rready held low while the data waits
task automatic read_stalled(input csr_addr_t addr, input int stall,
                            output axil_data_t data);
   int n;
   n = 0;
   @(posedge aclk_i);
   s_araddr_i  <= addr;
   s_arvalid_i <= 1'b1;
   @(negedge aclk_i);
   while (!s_rvalid_o && n < WAIT_LIMIT) begin
      @(negedge aclk_i);
      n++;
   end
   if (!s_rvalid_o) begin
      timeout_abort("s_rvalid_o on a stalled read");
   end
   // arvalid stays high while the data is held
   repeat (stall) @(negedge aclk_i);
   // another address after acceptance must not reach rdata
   @(posedge aclk_i);
   s_arvalid_i <= 1'b0;
   s_araddr_i  <= ~addr;
   repeat (stall) @(negedge aclk_i);
   @(posedge aclk_i);
   s_rready_i <= 1'b1;
   @(negedge aclk_i);
   data = s_rdata_o;
   check_equal(32'(s_rresp_o), 32'(RESP_OKAY), "stalled read response");
   @(posedge aclk_i);
   s_rready_i <= 1'b0;
endtask

/* dv/tb_zynq_pl_top.sv */
`timescale 1ns/10ps

module tb_zynq_pl_top
   import zynq_csr_pkg::*;
   import zynq_dram_pkg::*;
   ();

   localparam int WAIT_LIMIT = 64;

   logic       aclk_i;
   logic       arst_n_i;
   csr_addr_t  s_awaddr_i;
   logic       s_awvalid_i;
   logic       s_awready_o;
   axil_data_t s_wdata_i;
   axil_strb_t s_wstrb_i;
   logic       s_wvalid_i;
   logic       s_wready_o;
   axil_resp_t s_bresp_o;
   logic       s_bvalid_o;
   logic       s_bready_i;
   csr_addr_t  s_araddr_i;
   logic       s_arvalid_i;
   logic       s_arready_o;
   axil_data_t s_rdata_o;
   axil_resp_t s_rresp_o;
   logic       s_rvalid_o;
   logic       s_rready_i;
   axi_addr_t  core_awaddr_i;
   logic       core_awvalid_i;
   logic       core_awready_o;
   axi_addr_t  core_araddr_i;
   logic       core_arvalid_i;
   logic       core_arready_o;
   axi_addr_t  m00_axi_awaddr_o;
   logic       m00_axi_awvalid_o;
   logic       m00_axi_awready_i;
   axi_addr_t  m00_axi_araddr_o;
   logic       m00_axi_arvalid_o;
   logic       m00_axi_arready_i;
   logic       sys_resetn_o;

   int          error_cnt   = 0;
   int          check_cnt   = 0;
   int          timeout_cnt = 0;
   logic [31:0] lfsr_state  = 32'h9885_f7e2;

   // reference model
   axi_addr_t model_base;
   logic      model_resetn;
   profile_t  model_profile;

   task automatic report_error(input string msg);
      error_cnt++;
      $display("[ERROR] %0t ns: %s", $time, msg);
   endtask

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      check_cnt++;
      assert (got === exp) else begin
         report_error($sformatf("%s: got %h, expected %h", what, got, exp));
      end
   endtask

   task automatic finish_run();
      $display("checks: %0d, errors: %0d, timeouts: %0d", check_cnt, error_cnt, timeout_cnt);
      if (error_cnt == 0 && timeout_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   endtask

   task automatic timeout_abort(input string what);
      timeout_cnt++;
      $display("timeout: no %s within %0d cycles at %0t ns", what, WAIT_LIMIT, $time);
      finish_run();
   endtask

   `include "tb_axil_tasks.svh"

   zynq_pl_top i_zynq_pl_top (.*);

   initial begin
      aclk_i = 1'b0;
      forever #10 aclk_i = ~aclk_i;
   end

   //////////////////////////////
   // handshake checks
   //////////////////////////////
   assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      s_bvalid_o && !s_bready_i |=> s_bvalid_o)
      else report_error("bvalid dropped before bready");
   assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      s_bvalid_o |-> !s_awready_o)
      else report_error("write accepted while bvalid held");
   assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      s_awready_o && s_awvalid_i |=> s_bvalid_o)
      else report_error("no bvalid after write acceptance");
   assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      s_awready_o == s_wready_o)
      else report_error("awready and wready differ");
   assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o))
      else report_error("read data not held under back-pressure");
   assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      s_rvalid_o |-> !s_arready_o)
      else report_error("read accepted while rvalid held");
   assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      m00_axi_awvalid_o == core_awvalid_i && core_awready_o == m00_axi_awready_i)
      else report_error("aw valid or ready not passed through");
   assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      m00_axi_arvalid_o == core_arvalid_i && core_arready_o == m00_axi_arready_i)
      else report_error("ar valid or ready not passed through");

   //////////////////////////////
   // core traffic and profile
   //////////////////////////////
   task automatic run_core_traffic(input int cycles);
      axi_addr_t  aw;
      axi_addr_t  ar;
      logic [3:0] ctl;
      for (int i = 0; i < cycles; i++) begin
         aw  = rand_bits(32);
         ar  = rand_bits(32);
         ctl = 4'(rand_bits(4));
         @(posedge aclk_i);
         core_awaddr_i     <= aw;
         core_awvalid_i    <= ctl[0];
         core_araddr_i     <= ar;
         core_arvalid_i    <= ctl[1];
         m00_axi_awready_i <= ctl[2];
         m00_axi_arready_i <= ctl[3];
         // region index is core address bits 29:23
         if (ctl[0] && model_resetn) begin
            model_profile[aw[29:23]] = 1'b1;
         end
         if (ctl[1] && model_resetn) begin
            model_profile[ar[29:23]] = 1'b1;
         end
         @(negedge aclk_i);
         // bit 31 flipped, then the base added
         check_equal(m00_axi_awaddr_o, {~aw[31], aw[30:0]} + model_base, "aw remap");
         check_equal(m00_axi_araddr_o, {~ar[31], ar[30:0]} + model_base, "ar remap");
      end
      @(posedge aclk_i);
      core_awvalid_i <= 1'b0;
      core_arvalid_i <= 1'b0;
   endtask

   task automatic check_profile(input string what);
      axil_data_t word;
      for (int k = 0; k < 4; k++) begin
         axil_read(PROFILE_OFFSET + csr_addr_t'(4 * k), word);
         check_equal(word, model_profile[32*k +: 32], $sformatf("%s word %0d", what, k));
      end
   endtask

   initial begin
      axil_data_t word;
      axil_data_t val;
      arst_n_i          = 1'b0;
      s_awaddr_i        = '0;
      s_awvalid_i       = 1'b0;
      s_wdata_i         = '0;
      s_wstrb_i         = '0;
      s_wvalid_i        = 1'b0;
      s_bready_i        = 1'b0;
      s_araddr_i        = '0;
      s_arvalid_i       = 1'b0;
      s_rready_i        = 1'b0;
      core_awaddr_i     = '0;
      core_awvalid_i    = 1'b0;
      core_araddr_i     = '0;
      core_arvalid_i    = 1'b0;
      m00_axi_awready_i = 1'b0;
      m00_axi_arready_i = 1'b0;
      model_base        = '0;
      model_resetn      = 1'b0;
      model_profile     = '0;
      repeat (16) @(posedge aclk_i);
      arst_n_i <= 1'b1;

      // state after reset
      @(negedge aclk_i);
      check_equal(32'(sys_resetn_o), 32'd0, "sys_resetn after reset");
      check_equal(32'(s_bvalid_o), 32'd0, "bvalid after reset");
      check_equal(32'(s_rvalid_o), 32'd0, "rvalid after reset");
      check_profile("reset profile");

      // register access with full and partial strobes
      val = rand_bits(32);
      axil_write(DRAM_BASE_OFFSET, val, 4'hf);
      model_base = val;
      axil_read(DRAM_BASE_OFFSET, word);
      check_equal(word, model_base, "dram base readback");
      val = rand_bits(32);
      axil_write(DRAM_BASE_OFFSET, val, 4'b0101);
      model_base = {model_base[31:24], val[23:16], model_base[15:8], val[7:0]};
      axil_read(DRAM_BASE_OFFSET, word);
      check_equal(word, model_base, "dram base strobed readback");
      axil_write(SYS_RESET_OFFSET, 32'h1, 4'h1);
      model_resetn = 1'b1;
      @(negedge aclk_i);
      check_equal(32'(sys_resetn_o), 32'd1, "sys_resetn released");
      axil_read(SYS_RESET_OFFSET, word);
      check_equal(word, 32'd1, "sys reset readback");
      axil_read(10'h3fc, word);
      check_equal(word, 32'd0, "unmapped read");

      // remap and profile over several bases
      for (int b = 0; b < 3; b++) begin
         val = rand_bits(32);
         axil_write(DRAM_BASE_OFFSET, val, 4'hf);
         model_base = val;
         run_core_traffic(24);
         check_profile("profile");
      end

      // holding the system in reset clears the profile
      axil_write(SYS_RESET_OFFSET, 32'h0, 4'h1);
      model_resetn  = 1'b0;
      model_profile = '0;
      @(negedge aclk_i);
      check_equal(32'(sys_resetn_o), 32'd0, "sys_resetn asserted");
      check_profile("cleared profile");

      // write response back-pressure
      write_issue(DRAM_BASE_OFFSET, 32'h1357_9bdf, 4'hf);
      repeat (4) @(negedge aclk_i);
      check_equal(32'(s_bvalid_o), 32'd1, "bvalid under back-pressure");
      val = rand_bits(32);
      fork
         write_issue(DRAM_BASE_OFFSET, val, 4'hf);
         begin
            repeat (4) @(negedge aclk_i);
            check_equal(32'(s_awready_o), 32'd0, "awready while bvalid held");
            write_resp();
         end
      join
      write_resp();
      model_base = val;
      read_stalled(DRAM_BASE_OFFSET, 3, word);
      check_equal(word, model_base, "second write readback");

      finish_run();
   end

endmodule

/* hdl/axil_csr_shell.sv */
`timescale 1ns/10ps

module axil_csr_shell
   import zynq_csr_pkg::*;
   import zynq_dram_pkg::*;
  (input  logic       aclk_i
   , input  logic       arst_n_i

   // write address and data
   , input  csr_addr_t  s_awaddr_i
   , input  logic       s_awvalid_i
   , output logic       s_awready_o
   , input  axil_data_t s_wdata_i
   , input  axil_strb_t s_wstrb_i
   , input  logic       s_wvalid_i
   , output logic       s_wready_o

   // write response
   , output axil_resp_t s_bresp_o
   , output logic       s_bvalid_o
   , input  logic       s_bready_i

   // read address and data
   , input  csr_addr_t  s_araddr_i
   , input  logic       s_arvalid_i
   , output logic       s_arready_o
   , output axil_data_t s_rdata_o
   , output axil_resp_t s_rresp_o
   , output logic       s_rvalid_o
   , input  logic       s_rready_i

   // register side
   , input  profile_t   profile_i
   , output logic       sys_resetn_o
   , output axi_addr_t  dram_base_o
   );

   wr_state_e  wr_state_r;
   rd_state_e  rd_state_r;
   logic       wr_accept;
   logic       rd_accept;
   logic       sys_resetn_r;
   axi_addr_t  dram_base_r;
   axil_data_t rd_word;
   axil_data_t rdata_r;

   //////////////////////////////
   // write channel
   //////////////////////////////
   // address and data must arrive together
   assign wr_accept   = (wr_state_r == WR_IDLE) && s_awvalid_i && s_wvalid_i;
   assign s_awready_o = wr_accept;
   assign s_wready_o  = wr_accept;
   assign s_bvalid_o  = (wr_state_r == WR_RESP);
   assign s_bresp_o   = RESP_OKAY;

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_state_r <= WR_IDLE;
      end else begin
         case (wr_state_r)
            WR_IDLE: begin
               if (wr_accept) begin
                  wr_state_r <= WR_RESP;
               end
            end
            WR_RESP: begin
               if (s_bready_i) begin
                  wr_state_r <= WR_IDLE;
               end
            end
            default: wr_state_r <= WR_IDLE;
         endcase
      end
   end

   // byte strobes applied per lane
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sys_resetn_r <= 1'b0;
         dram_base_r  <= '0;
      end else if (wr_accept) begin
         if (s_awaddr_i == SYS_RESET_OFFSET && s_wstrb_i[0]) begin
            sys_resetn_r <= s_wdata_i[0];
         end
         if (s_awaddr_i == DRAM_BASE_OFFSET) begin
            for (int b = 0; b < AXIL_STRB_W; b++) begin
               if (s_wstrb_i[b]) begin
                  dram_base_r[8*b +: 8] <= s_wdata_i[8*b +: 8];
               end
            end
         end
      end
   end

   assign sys_resetn_o = sys_resetn_r;
   assign dram_base_o  = dram_base_r;

   //////////////////////////////
   // read channel
   //////////////////////////////
   assign rd_accept   = (rd_state_r == RD_IDLE) && s_arvalid_i;
   assign s_arready_o = rd_accept;
   assign s_rvalid_o  = (rd_state_r == RD_DATA);
   assign s_rresp_o   = RESP_OKAY;

   // unmapped reads return zero
   always_comb begin
      rd_word = '0;
      if (s_araddr_i == SYS_RESET_OFFSET) begin
         rd_word = axil_data_t'(sys_resetn_r);
      end else if (s_araddr_i == DRAM_BASE_OFFSET) begin
         rd_word = dram_base_r;
      end
      for (int k = 0; k < PROFILE_WORDS; k++) begin
         if (s_araddr_i == csr_addr_t'(PROFILE_OFFSET + 4 * k)) begin
            rd_word = profile_i[PROFILE_WORD_W*k +: PROFILE_WORD_W];
         end
      end
   end

   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rd_state_r <= RD_IDLE;
      end else begin
         case (rd_state_r)
            RD_IDLE: begin
               if (rd_accept) begin
                  rd_state_r <= RD_DATA;
               end
            end
            RD_DATA: begin
               if (s_rready_i) begin
                  rd_state_r <= RD_IDLE;
               end
            end
            default: rd_state_r <= RD_IDLE;
         endcase
      end
   end

   // data captured at acceptance and held under back-pressure
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rdata_r <= '0;
      end else if (rd_accept) begin
         rdata_r <= rd_word;
      end
   end

   assign s_rdata_o = rdata_r;

endmodule

/* hdl/dram_port_monitor.sv */
`timescale 1ns/10ps

module dram_port_monitor
   import zynq_dram_pkg::*;
  (input  logic      aclk_i
   , input  logic      arst_n_i
   , input  logic      sys_resetn_i
   , input  axi_addr_t dram_base_i

   // core side
   , input  axi_addr_t core_awaddr_i
   , input  logic      core_awvalid_i
   , output logic      core_awready_o
   , input  axi_addr_t core_araddr_i
   , input  logic      core_arvalid_i
   , output logic      core_arready_o

   // zynq hp port side
   , output axi_addr_t m00_axi_awaddr_o
   , output logic      m00_axi_awvalid_o
   , input  logic      m00_axi_awready_i
   , output axi_addr_t m00_axi_araddr_o
   , output logic      m00_axi_arvalid_o
   , input  logic      m00_axi_arready_i

   , output profile_t  profile_o
   );

   region_idx_t aw_region;
   region_idx_t ar_region;
   profile_t    profile_r;
   profile_t    profile_nxt;

   //////////////////////////////
   // address remap
   //////////////////////////////
   // strip the core dram base, then move into the allocated arm region
   assign m00_axi_awaddr_o  = (core_awaddr_i ^ CORE_DRAM_BASE) + dram_base_i;
   assign m00_axi_araddr_o  = (core_araddr_i ^ CORE_DRAM_BASE) + dram_base_i;

   assign m00_axi_awvalid_o = core_awvalid_i;
   assign m00_axi_arvalid_o = core_arvalid_i;
   assign core_awready_o    = m00_axi_awready_i;
   assign core_arready_o    = m00_axi_arready_i;

   //////////////////////////////
   // region profiler
   //////////////////////////////
   // uses the untranslated core address
   assign aw_region = core_awaddr_i[REGION_MSB -: REGION_IDX_W];
   assign ar_region = core_araddr_i[REGION_MSB -: REGION_IDX_W];

   always_comb begin
      profile_nxt = profile_r;
      if (core_awvalid_i) begin
         profile_nxt[aw_region] = 1'b1;
      end
      if (core_arvalid_i) begin
         profile_nxt[ar_region] = 1'b1;
      end
   end

   // sticky bits, cleared while the system sits in reset
   always_ff @(posedge aclk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         profile_r <= '0;
      end else if (!sys_resetn_i) begin
         profile_r <= '0;
      end else begin
         profile_r <= profile_nxt;
      end
   end

   assign profile_o = profile_r;

endmodule

/* hdl/zynq_csr_pkg.sv */
package zynq_csr_pkg;

   //////////////////////////////
   // axi-lite widths and types
   //////////////////////////////
   localparam int CSR_ADDR_W  = 10;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   typedef logic [CSR_ADDR_W-1:0]  csr_addr_t;
   typedef logic [AXIL_DATA_W-1:0] axil_data_t;
   typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
   typedef logic [1:0]             axil_resp_t;

   localparam axil_resp_t RESP_OKAY = 2'b00;

   //////////////////////////////
   // register map
   //////////////////////////////
   // active-low system reset, bit 0 only
   localparam csr_addr_t SYS_RESET_OFFSET = 10'h000;
   localparam csr_addr_t DRAM_BASE_OFFSET = 10'h004;
   // first of the read-only profile words, one every 4 bytes
   localparam csr_addr_t PROFILE_OFFSET   = 10'h008;

   // shell channel states
   typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
   typedef enum logic {RD_IDLE, RD_DATA} rd_state_e;

endpackage

/* hdl/zynq_dram_pkg.sv */
package zynq_dram_pkg;

   //////////////////////////////
   // dram address space
   //////////////////////////////
   localparam int AXI_ADDR_W = 32;

   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;

   // core dram starts here, removed by xor before the base is added
   localparam axi_addr_t CORE_DRAM_BASE = 32'h8000_0000;

   //////////////////////////////
   // region profile
   //////////////////////////////
   localparam int PROFILE_REGIONS = 128;
   localparam int REGION_IDX_W    = 7;
   // index taken from bits 29:23, so 8 MiB per region
   localparam int REGION_MSB      = 29;
   localparam int PROFILE_WORD_W  = 32;
   localparam int PROFILE_WORDS   = PROFILE_REGIONS / PROFILE_WORD_W;

   typedef logic [PROFILE_REGIONS-1:0] profile_t;
   typedef logic [REGION_IDX_W-1:0]    region_idx_t;

endpackage

/* hdl/zynq_pl_top.sv */
`timescale 1ns/10ps

module zynq_pl_top
   import zynq_csr_pkg::*;
   import zynq_dram_pkg::*;
  (input  logic       aclk_i
   , input  logic       arst_n_i

   // ps axi-lite slave
   , input  csr_addr_t  s_awaddr_i
   , input  logic       s_awvalid_i
   , output logic       s_awready_o
   , input  axil_data_t s_wdata_i
   , input  axil_strb_t s_wstrb_i
   , input  logic       s_wvalid_i
   , output logic       s_wready_o
   , output axil_resp_t s_bresp_o
   , output logic       s_bvalid_o
   , input  logic       s_bready_i
   , input  csr_addr_t  s_araddr_i
   , input  logic       s_arvalid_i
   , output logic       s_arready_o
   , output axil_data_t s_rdata_o
   , output axil_resp_t s_rresp_o
   , output logic       s_rvalid_o
   , input  logic       s_rready_i

   // core dram address channels
   , input  axi_addr_t  core_awaddr_i
   , input  logic       core_awvalid_i
   , output logic       core_awready_o
   , input  axi_addr_t  core_araddr_i
   , input  logic       core_arvalid_i
   , output logic       core_arready_o

   // hp port address channels
   , output axi_addr_t  m00_axi_awaddr_o
   , output logic       m00_axi_awvalid_o
   , input  logic       m00_axi_awready_i
   , output axi_addr_t  m00_axi_araddr_o
   , output logic       m00_axi_arvalid_o
   , input  logic       m00_axi_arready_i

   // reset for the core, low true
   , output logic       sys_resetn_o
   );

   axi_addr_t dram_base;
   profile_t  profile;

   axil_csr_shell i_axil_csr_shell
     (.aclk_i       (aclk_i)
      ,.arst_n_i    (arst_n_i)
      ,.s_awaddr_i  (s_awaddr_i)
      ,.s_awvalid_i (s_awvalid_i)
      ,.s_awready_o (s_awready_o)
      ,.s_wdata_i   (s_wdata_i)
      ,.s_wstrb_i   (s_wstrb_i)
      ,.s_wvalid_i  (s_wvalid_i)
      ,.s_wready_o  (s_wready_o)
      ,.s_bresp_o   (s_bresp_o)
      ,.s_bvalid_o  (s_bvalid_o)
      ,.s_bready_i  (s_bready_i)
      ,.s_araddr_i  (s_araddr_i)
      ,.s_arvalid_i (s_arvalid_i)
      ,.s_arready_o (s_arready_o)
      ,.s_rdata_o   (s_rdata_o)
      ,.s_rresp_o   (s_rresp_o)
      ,.s_rvalid_o  (s_rvalid_o)
      ,.s_rready_i  (s_rready_i)
      ,.profile_i   (profile)
      ,.sys_resetn_o(sys_resetn_o)
      ,.dram_base_o (dram_base)
      );

   dram_port_monitor i_dram_port_monitor
     (.aclk_i            (aclk_i)
      ,.arst_n_i         (arst_n_i)
      ,.sys_resetn_i     (sys_resetn_o)
      ,.dram_base_i      (dram_base)
      ,.core_awaddr_i    (core_awaddr_i)
      ,.core_awvalid_i   (core_awvalid_i)
      ,.core_awready_o   (core_awready_o)
      ,.core_araddr_i    (core_araddr_i)
      ,.core_arvalid_i   (core_arvalid_i)
      ,.core_arready_o   (core_arready_o)
      ,.m00_axi_awaddr_o (m00_axi_awaddr_o)
      ,.m00_axi_awvalid_o(m00_axi_awvalid_o)
      ,.m00_axi_awready_i(m00_axi_awready_i)
      ,.m00_axi_araddr_o (m00_axi_araddr_o)
      ,.m00_axi_arvalid_o(m00_axi_arvalid_o)
      ,.m00_axi_arready_i(m00_axi_arready_i)
      ,.profile_o        (profile)
      );

endmodule

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_zynq_pl_top \
   -o tb_zynq_pl_top > build.log 2>&1 \
   && ./obj_dir/tb_zynq_pl_top > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "^Simulation finished: PASS$" sim.log && echo "test passed" \
   || { echo "test failed"; exit 1; }
